// ==== rtl/fir_chain_pkg.sv ====
package fir_chain_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data types along the chain
  ////////////////////////////////////////////////////////////////////////////

  // ADC or sawtooth sample, two's complement
  typedef logic signed [13:0] sample_t;

  // FIR coefficient, two's complement
  typedef logic signed [15:0] coeff_t;

  // Filter output, 30-bit product plus 6 guard bits for up to 64 taps
  typedef logic signed [35:0] result_t;

  // Sample source selection
  typedef enum logic [1:0]
  {
    SRC_ADC   = 2'd0, // External ADC port
    SRC_SYNTH = 2'd1, // Built-in sawtooth
    SRC_OFF   = 2'd2  // No samples
  } src_sel_e;

  ////////////////////////////////////////////////////////////////////////////
  // Default sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int DEF_FIFO_DEPTH = 8;
  localparam int DEF_N_TAPS     = 8; // Legal range 2 to 64

  // Sawtooth origin and increment
  // 32 steps of 512 cover the whole 14-bit range, then wrap
  localparam sample_t SYNTH_START = -14'sd8192;
  localparam sample_t SYNTH_STEP  = 14'sd512;

endpackage

// ==== rtl/sample_source.sv ====
`timescale 1ns/1ps

module sample_source
#(
  parameter int FIFO_DEPTH = 8
)
(
  input  logic                   clk_custom,
  input  logic                   arst_n,
  input  logic                   enable,
  input  fir_chain_pkg::src_sel_e src_sel,
  input  fir_chain_pkg::sample_t adc_sample,
  input  logic                   adc_valid,
  input  logic                   credit_return, // One per pop from the buffer
  output logic                   push,
  output fir_chain_pkg::sample_t push_sample,
  output logic                   overrun        // Sticky until reset
);

  import fir_chain_pkg::*;

  localparam int CW = $clog2(FIFO_DEPTH + 1);

  logic [CW-1:0] credit_cnt;  // Free slots in the buffer
  logic          has_credit;
  logic          want;        // Sample offered this cycle
  logic          reserve;     // Sample accepted, credit taken
  logic          drop;        // ADC sample lost
  sample_t       next_sample;
  sample_t       ramp_q;      // Sawtooth phase

  ////////////////////////////////////////////////////////////////////////////
  // Source select
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (src_sel)
      SRC_ADC:
      begin
        want        = enable && adc_valid; // Capture only while enabled
        next_sample = adc_sample;
      end
      SRC_SYNTH:
      begin
        want        = enable;              // One ramp point per credited cycle
        next_sample = ramp_q;
      end
      default:
      begin
        want        = 1'b0;
        next_sample = ramp_q;
      end
    endcase
  end

  assign has_credit = (credit_cnt != '0);
  assign reserve    = want && has_credit;
  assign drop       = want && !has_credit && (src_sel == SRC_ADC); // Synth just waits

  ////////////////////////////////////////////////////////////////////////////
  // Credits, push and overrun
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_custom or negedge arst_n)
  begin
    if (!arst_n)
    begin
      credit_cnt <= CW'(FIFO_DEPTH); // Buffer starts empty
      push       <= 1'b0;
      overrun    <= 1'b0;
      ramp_q     <= SYNTH_START;
    end
    else
    begin
      credit_cnt <= credit_cnt + CW'(credit_return) - CW'(reserve);
      push       <= reserve;          // Push lands one cycle after capture
      if (drop)
        overrun <= 1'b1;
      if (reserve && src_sel == SRC_SYNTH)
        ramp_q <= ramp_q + SYNTH_STEP; // Natural 14-bit wrap
    end
  end

  // Payload, qualified by push
  always_ff @(posedge clk_custom)
  begin
    if (reserve)
      push_sample <= next_sample;
  end

  // Buffer must hand back exactly what it took
  a_credit_bound: assert property (@(posedge clk_custom) disable iff (!arst_n)
    credit_cnt <= FIFO_DEPTH);

endmodule

// ==== rtl/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo
#(
  parameter int FIFO_DEPTH = 8
)
(
  input  logic                   clk_custom,
  input  logic                   arst_n,
  input  logic                   push,
  input  fir_chain_pkg::sample_t push_sample,
  input  logic                   pop,           // Legal only with avail high
  output logic                   avail,         // Non-empty
  output fir_chain_pkg::sample_t head_sample,
  output logic                   credit_return  // Registered, one per pop
);

  import fir_chain_pkg::*;

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  sample_t       mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;    // Occupancy

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_custom or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Any depth
      if (pop)
        rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count         <= count + CW'(push) - CW'(pop);
      credit_return <= pop; // Slot freed, tell the producer
    end
  end

  // Storage
  always_ff @(posedge clk_custom)
  begin
    if (push)
      mem[wr_ptr] <= push_sample;
  end

  assign avail       = (count != '0);
  assign head_sample = mem[rd_ptr]; // Valid one cycle after the push

  ////////////////////////////////////////////////////////////////////////////
  // Link checks
  ////////////////////////////////////////////////////////////////////////////

  // Credit flow on the producer side must keep us from filling past depth
  a_no_push_full: assert property (@(posedge clk_custom) disable iff (!arst_n)
    push |-> (count < FIFO_DEPTH));

  // Consumer pops only what is there
  a_no_pop_empty: assert property (@(posedge clk_custom) disable iff (!arst_n)
    pop |-> avail);

endmodule

// ==== rtl/fir_engine.sv ====
`timescale 1ns/1ps

module fir_engine
#(
  parameter int N_TAPS = 8
)
(
  input  logic                       clk_custom,
  input  logic                       arst_n,
  input  logic                       avail,
  input  fir_chain_pkg::sample_t     head_sample,
  input  logic                       bypass,       // Pass samples through
  input  logic                       coeff_wr,
  input  logic [$clog2(N_TAPS)-1:0]  coeff_addr,
  input  fir_chain_pkg::coeff_t      coeff_data,
  input  logic                       out_ready,
  output logic                       pop,
  output logic                       out_valid,
  output fir_chain_pkg::result_t     out_sample
);

  import fir_chain_pkg::*;

  coeff_t  coeff_q [N_TAPS];    // Runtime coefficient file
  sample_t dly_q   [N_TAPS-1];  // Older samples, head_sample is tap 0
  sample_t tap     [N_TAPS];    // Window seen by this pop
  result_t fir_sum;

  ////////////////////////////////////////////////////////////////////////////
  // Coefficient register file
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_custom or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < N_TAPS; i++)
        coeff_q[i] <= (i == 0) ? coeff_t'(1) : coeff_t'(0); // Identity filter
    end
    else if (coeff_wr)
    begin
      coeff_q[coeff_addr] <= coeff_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Delay line and MAC
  ////////////////////////////////////////////////////////////////////////////

  // Pop when a sample waits and the output slot is free or freeing
  assign pop = avail && (!out_valid || out_ready);

  always_comb
  begin
    tap[0] = head_sample; // Newest
    for (int k = 1; k < N_TAPS; k++)
      tap[k] = dly_q[k-1];
  end

  // Sum of products, widened before multiply
  always_comb
  begin
    fir_sum = '0;
    for (int k = 0; k < N_TAPS; k++)
      fir_sum = fir_sum + result_t'(coeff_q[k]) * result_t'(tap[k]);
  end

  always_ff @(posedge clk_custom or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < N_TAPS - 1; i++)
        dly_q[i] <= '0;
    end
    else if (pop)
    begin
      dly_q[0] <= head_sample; // Shifts in bypass too
      for (int i = 1; i < N_TAPS - 1; i++)
        dly_q[i] <= dly_q[i-1];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_custom or negedge arst_n)
  begin
    if (!arst_n)
      out_valid <= 1'b0;
    else if (pop)
      out_valid <= 1'b1;      // Rises one cycle after the pop
    else if (out_ready)
      out_valid <= 1'b0;      // Drained
  end

  always_ff @(posedge clk_custom)
  begin
    if (pop)
      out_sample <= bypass ? result_t'(head_sample) : fir_sum; // Sign-extended in bypass
  end

  // Result must hold across a stall
  a_stall_stable: assert property (@(posedge clk_custom) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_sample));

endmodule

// ==== rtl/fir_signal_chain.sv ====
`timescale 1ns/1ps

module fir_signal_chain
#(
  parameter int FIFO_DEPTH = fir_chain_pkg::DEF_FIFO_DEPTH,
  parameter int N_TAPS     = fir_chain_pkg::DEF_N_TAPS
)
(
  input  logic                       clk_custom,
  input  logic                       arst_n,
  input  logic                       enable,
  input  fir_chain_pkg::src_sel_e    src_sel,
  input  logic                       bypass,
  input  fir_chain_pkg::sample_t     adc_sample,
  input  logic                       adc_valid,
  input  logic                       coeff_wr,
  input  logic [$clog2(N_TAPS)-1:0]  coeff_addr,
  input  fir_chain_pkg::coeff_t      coeff_data,
  input  logic                       out_ready,
  output logic                       out_valid,
  output fir_chain_pkg::result_t     out_sample,
  output logic                       overrun
);

  import fir_chain_pkg::*;

  // Producer to buffer, credit flow
  logic    push;
  sample_t push_sample;
  logic    credit_return;

  // Buffer to consumer, valid and pop
  logic    avail;
  sample_t head_sample;
  logic    pop;

  ////////////////////////////////////////////////////////////////////////////
  // Source, buffer, filter
  ////////////////////////////////////////////////////////////////////////////

  sample_source #(.FIFO_DEPTH(FIFO_DEPTH)) i_source
  (
    .clk_custom    (clk_custom),
    .arst_n        (arst_n),
    .enable        (enable),
    .src_sel       (src_sel),
    .adc_sample    (adc_sample),
    .adc_valid     (adc_valid),
    .credit_return (credit_return),
    .push          (push),
    .push_sample   (push_sample),
    .overrun       (overrun)
  );

  sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo
  (
    .clk_custom    (clk_custom),
    .arst_n        (arst_n),
    .push          (push),
    .push_sample   (push_sample),
    .pop           (pop),
    .avail         (avail),
    .head_sample   (head_sample),
    .credit_return (credit_return)
  );

  fir_engine #(.N_TAPS(N_TAPS)) i_engine
  (
    .clk_custom  (clk_custom),
    .arst_n      (arst_n),
    .avail       (avail),
    .head_sample (head_sample),
    .bypass      (bypass),
    .coeff_wr    (coeff_wr),
    .coeff_addr  (coeff_addr),
    .coeff_data  (coeff_data),
    .out_ready   (out_ready),
    .pop         (pop),
    .out_valid   (out_valid),
    .out_sample  (out_sample)
  );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
#(
  parameter real PERIOD_NS = 4.0
)
(
  output logic clk_custom
);

  // Free-running, starts low
  initial
  begin
    clk_custom = 1'b0;
    forever
      #(PERIOD_NS / 2.0) clk_custom = ~clk_custom; // Half period per phase
  end

endmodule

// ==== verif/tb_fir_signal_chain.sv ====
`timescale 1ns/1ps

module tb_fir_signal_chain;

  import fir_chain_pkg::*;

  localparam int FIFO_DEPTH = DEF_FIFO_DEPTH;
  localparam int N_TAPS     = DEF_N_TAPS;
  localparam int AW         = $clog2(N_TAPS);

  // Ramp as the source should produce it
  localparam sample_t RAMP_START = -14'sd8192;
  localparam sample_t RAMP_STEP  = 14'sd512;

  // Planned sample counts per test
  localparam int N_IDENT = 40;
  localparam int N_SYNTH = 100;
  localparam int N_BACKP = 200;
  localparam int N_BYP   = 60;
  localparam int N_OFF   = 50;
  localparam int N_OVR   = 20;
  localparam int LIMIT   = 4 * (N_IDENT + N_SYNTH + N_BACKP + N_BYP + N_OFF + N_OVR) + 1000;

  logic            clk_custom;
  logic            arst_n;
  logic            enable;
  src_sel_e        src_sel;
  logic            bypass;
  sample_t         adc_sample;
  logic            adc_valid;
  logic            coeff_wr;
  logic [AW-1:0]   coeff_addr;
  coeff_t          coeff_data;
  logic            out_ready;
  logic            out_valid;
  result_t         out_sample;
  logic            overrun;

  // Reference model state
  sample_t     hist [$];          // Samples seen by the filter, oldest first
  sample_t     adc_q [$];         // ADC samples sent, not yet out
  coeff_t      coeff_m [N_TAPS];
  sample_t     ramp_m;            // Next ramp point
  bit          exp_synth;         // Outputs come from the ramp
  bit          bypass_m;
  string       test_name;
  int          n_out;             // Transfers so far
  int          cycle_cnt;
  logic [31:0] lfsr_state;
  bit          stall_prev;
  result_t     held_sample;

  tb_clock_gen #(.PERIOD_NS(4.0)) i_clk (.clk_custom(clk_custom));

  fir_signal_chain #(.FIFO_DEPTH(FIFO_DEPTH), .N_TAPS(N_TAPS)) i_dut
  (
    .clk_custom (clk_custom),
    .arst_n     (arst_n),
    .enable     (enable),
    .src_sel    (src_sel),
    .bypass     (bypass),
    .adc_sample (adc_sample),
    .adc_valid  (adc_valid),
    .coeff_wr   (coeff_wr),
    .coeff_addr (coeff_addr),
    .coeff_data (coeff_data),
    .out_ready  (out_ready),
    .out_valid  (out_valid),
    .out_sample (out_sample),
    .overrun    (overrun)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Random bits, reference and checks
  ////////////////////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      val        = {val[30:0], lfsr_state[0]}; // One step per bit
    end
  endtask

  // Expected output for the newest entry of hist
  function automatic result_t fir_ref(input bit byp);
    longint acc;
    int     last;
    acc  = 0;
    last = hist.size() - 1;
    if (byp)
      return result_t'(hist[last]);                  // Sign-extended sample
    for (int k = 0; k < N_TAPS && k <= last; k++)
      acc += longint'(coeff_m[k]) * longint'(hist[last - k]); // Missing history is zero
    return result_t'(acc);
  endfunction

  task automatic check_value(input string name, input logic signed [63:0] expected,
                             input logic signed [63:0] actual);
    if (expected !== actual)
    begin
      $display("mismatch %s expected %0d actual %0d", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "run aborted");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare process, sampled mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_custom)
  begin : compare_outputs
    sample_t s;
    result_t expected;
    if (!arst_n)
      stall_prev = 1'b0;
    else
    begin
      if (stall_prev) // Stalled last cycle, result must hold
      begin
        check_value({test_name, " stall valid"}, 1, out_valid);
        check_value({test_name, " stall hold"}, held_sample, out_sample);
      end
      if (out_valid && out_ready) // Transfer on the coming edge
      begin
        if (!exp_synth && adc_q.size() == 0)
          fail_run("an output appeared although no ADC sample was waiting");
        else
        begin
          if (exp_synth)
          begin
            s      = ramp_m;
            ramp_m = ramp_m + RAMP_STEP; // 14-bit wrap
          end
          else
            s = adc_q.pop_front();
          hist.push_back(s);
          if (hist.size() > N_TAPS)
            void'(hist.pop_front());
          expected = fir_ref(bypass_m);
          check_value(test_name, expected, out_sample);
          n_out++;
        end
      end
      stall_prev  = out_valid && !out_ready;
      held_sample = out_sample;
    end
  end

  // Hang guard
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < LIMIT)
    begin
      @(posedge clk_custom);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", LIMIT);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_dut();
    @(posedge clk_custom);
    arst_n    <= 1'b0;
    enable    <= 1'b0;
    adc_valid <= 1'b0;
    coeff_wr  <= 1'b0;
    bypass    <= 1'b0;
    hist.delete();
    adc_q.delete();
    for (int i = 0; i < N_TAPS; i++)
      coeff_m[i] = (i == 0) ? coeff_t'(1) : coeff_t'(0); // Identity after reset
    ramp_m    = RAMP_START;
    exp_synth = 1'b0;
    bypass_m  = 1'b0;
    repeat (16) @(posedge clk_custom);
    arst_n <= 1'b1;
  endtask

  // Stop the source and wait for a quiet output
  task automatic drain();
    int idle;
    idle = 0;
    @(posedge clk_custom);
    enable    <= 1'b0;
    out_ready <= 1'b1;
    while (idle < 4)
    begin
      @(negedge clk_custom);
      idle = out_valid ? 0 : idle + 1;
    end
  endtask

  task automatic load_coeffs();
    logic [31:0] r;
    for (int i = 0; i < N_TAPS; i++)
    begin
      take_bits(16, r);
      @(posedge clk_custom);
      coeff_wr   <= 1'b1;
      coeff_addr <= AW'(i);
      coeff_data <= coeff_t'(r[15:0]);
      coeff_m[i] = coeff_t'(r[15:0]);
    end
    @(posedge clk_custom);
    coeff_wr <= 1'b0;
  endtask

  task automatic run_synth(input string name, input int count, input bit rand_ready);
    logic [31:0] r;
    int          target;
    target = n_out + count;
    @(posedge clk_custom);
    test_name = name;
    exp_synth = 1'b1;
    src_sel   <= SRC_SYNTH;
    enable    <= 1'b1;
    while (n_out < target)
    begin
      @(posedge clk_custom);
      if (rand_ready)
      begin
        take_bits(1, r);
        out_ready <= r[0]; // Random stall
      end
    end
    drain();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : stimulus
    logic [31:0] r;
    arst_n     = 1'b0;
    enable     = 1'b0;
    src_sel    = SRC_OFF;
    bypass     = 1'b0;
    adc_sample = '0;
    adc_valid  = 1'b0;
    coeff_wr   = 1'b0;
    coeff_addr = '0;
    coeff_data = '0;
    out_ready  = 1'b1;
    lfsr_state = 32'h5bb7_30f6;
    n_out      = 0;
    test_name  = "reset";
    reset_dut();

    @(negedge clk_custom);
    check_value("reset out_valid", 0, out_valid);
    check_value("reset overrun", 0, overrun);

    // Slow ADC samples through the identity filter
    @(posedge clk_custom);
    test_name = "identity";
    src_sel   <= SRC_ADC;
    enable    <= 1'b1;
    for (int i = 0; i < N_IDENT; i++)
    begin
      take_bits(3, r);
      repeat (3 + r) @(posedge clk_custom);
      take_bits(14, r);
      adc_valid  <= 1'b1;
      adc_sample <= sample_t'(r[13:0]);
      adc_q.push_back(sample_t'(r[13:0]));
      @(posedge clk_custom);
      adc_valid <= 1'b0;
    end
    while (n_out < N_IDENT)
      @(posedge clk_custom);
    @(negedge clk_custom);
    check_value("identity overrun", 0, overrun); // Never short of credits
    drain();

    load_coeffs();
    run_synth("synth fir", N_SYNTH, 1'b0);
    run_synth("back-pressure", N_BACKP, 1'b1);

    // Bypass ignores the loaded coefficients
    @(posedge clk_custom);
    bypass   <= 1'b1;
    bypass_m = 1'b1;
    run_synth("bypass", N_BYP, 1'b0);
    @(posedge clk_custom);
    bypass   <= 1'b0;
    bypass_m = 1'b0;

    // Source off, nothing may come out
    @(posedge clk_custom);
    test_name = "off";
    src_sel   <= SRC_OFF;
    enable    <= 1'b1;
    repeat (N_OFF)
    begin
      @(negedge clk_custom);
      check_value("off out_valid", 0, out_valid);
    end

    // Flood the ADC port against a stalled output
    reset_dut();
    @(negedge clk_custom);
    check_value("overrun after reset", 0, overrun);
    test_name = "overrun";
    for (int i = 0; i < N_OVR; i++)
    begin
      take_bits(14, r);
      @(posedge clk_custom);
      src_sel    <= SRC_ADC;
      enable     <= 1'b1;
      out_ready  <= 1'b0;
      adc_valid  <= 1'b1;
      adc_sample <= sample_t'(r[13:0]);
    end
    @(posedge clk_custom);
    adc_valid <= 1'b0;
    @(negedge clk_custom);
    check_value("overrun flag", 1, overrun);

    if (adc_q.size() != 0)
      fail_run("some ADC samples that were sent never reached the output");
    else
    begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

// ==== vlog.f ====
rtl/fir_chain_pkg.sv
rtl/sample_source.sv
rtl/sample_fifo.sv
rtl/fir_engine.sv
rtl/fir_signal_chain.sv
verif/tb_clock_gen.sv
verif/tb_fir_signal_chain.sv

// ==== Bender.yml ====
package:
  name: fir_signal_chain

sources:
  # Design, in compile order
  - files:
      - rtl/fir_chain_pkg.sv
      - rtl/sample_source.sv
      - rtl/sample_fifo.sv
      - rtl/fir_engine.sv
      - rtl/fir_signal_chain.sv

  # Testbench
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_fir_signal_chain.sv
